//--- objPkg.sv
package objPkg;

    // **************************************************
    // Sizes and layout of object attribute memory
    // **************************************************

    localparam int oamBytes     = 1024;
    localparam int oamWords     = oamBytes / 4;
    localparam int affineGroups = 32;
    localparam int groupStride  = 32;   // Bytes covered by one affine group.
    localparam int paramOffset  = 6;    // PA sits in the upper half of the second word.
    localparam int paramStep    = 8;
    localparam int fracBits     = 8;

    typedef logic [$clog2(oamBytes)-1:0]     oamAddr;
    typedef logic [31:0]                     oamWord;
    typedef logic [$clog2(affineGroups)-1:0] affineIndex;
    typedef logic signed [15:0]              affineParam;   // 8.8 fixed point.
    typedef logic signed [9:0]               pixelOffset;
    typedef logic signed [15:0]              texCoord;

    // **************************************************
    // Bundles that move between blocks
    // **************************************************

    typedef struct packed {
        oamAddr addr;
        oamWord data;
    } oamWrite;

    typedef struct packed {
        affineParam pa;
        affineParam pb;
        affineParam pc;
        affineParam pd;
    } affineSet;

    typedef struct packed {
        affineIndex index;
        pixelOffset dx;
        pixelOffset dy;
    } pixelRequest;

    typedef struct packed {
        pixelRequest req;
        affineSet    params;
    } transformJob;

    typedef struct packed {
        texCoord tx;
        texCoord ty;
    } texResult;

endpackage

//--- oamMemory.sv
`timescale 1ns/1ps

module oamMemory (
    input  logic            clock,
    input  objPkg::oamWrite wr,
    input  logic            wrValid,
    input  objPkg::oamAddr  rdAddr,
    input  logic            rdEn,
    output objPkg::oamWord  rdData
);

    import objPkg::*;

    oamWord mem [oamWords];

    // Byte addresses select a word; the two low bits are ignored.
    always_ff @(posedge clock) begin
        if (wrValid) begin
            mem[wr.addr[$bits(oamAddr)-1:2]] <= wr.data;
        end
    end

    always_ff @(posedge clock) begin
        if (rdEn) begin
            rdData <= mem[rdAddr[$bits(oamAddr)-1:2]];   // One cycle read latency.
        end
    end

    // **************************************************
    // Checks
    // **************************************************

    writeAligned: assert property (
        @(posedge clock) wrValid |-> (wr.addr[1:0] == 2'b00)
    ) else $error("OAM write to unaligned address %h", wr.addr);

endmodule

//--- attributeLookupUnit.sv
`timescale 1ns/1ps

module attributeLookupUnit (
    input  logic               clock,
    input  logic               reset,
    input  logic               start,
    input  objPkg::affineIndex index,
    output objPkg::oamAddr     oamAddress,
    output logic               readOam,
    input  objPkg::oamWord     oamData,
    output objPkg::affineSet   params,
    output logic               done
);

    import objPkg::*;

    typedef enum logic [2:0] {
        idle,
        prep,
        writeA,
        writeB,
        writeC,
        writeD,
        finish
    } lookupState;

    lookupState state, nextState;
    oamAddr     addrReg;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= idle;
            done  <= 1'b0;
        end else begin
            state <= nextState;
            done  <= (state == finish);
        end
    end

    // The first address comes from the group number, the rest walk from the register.
    assign oamAddress = (state == prep) ? oamAddr'(index * groupStride + paramOffset)
                                        : addrReg;

    always_ff @(posedge clock) begin
        addrReg <= oamAddress + oamAddr'(paramStep);
    end

    // Read data lags the address by one cycle, so capture trails the read by one state.
    always_ff @(posedge clock) begin
        case (state)
            writeA: params.pa <= affineParam'(oamData[31:16]);
            writeB: params.pb <= affineParam'(oamData[31:16]);
            writeC: params.pc <= affineParam'(oamData[31:16]);
            writeD: params.pd <= affineParam'(oamData[31:16]);
            default: ;
        endcase
    end

    always_comb begin
        nextState = idle;
        readOam   = 1'b0;
        case (state)
            idle: nextState = start ? prep : idle;
            prep: begin
                readOam   = 1'b1;
                nextState = writeA;
            end
            writeA: begin
                readOam   = 1'b1;
                nextState = writeB;
            end
            writeB: begin
                readOam   = 1'b1;
                nextState = writeC;
            end
            writeC: begin
                readOam   = 1'b1;
                nextState = writeD;
            end
            writeD: nextState = finish;
            finish: nextState = idle;
            default: nextState = idle;
        endcase
    end

    // **************************************************
    // Checks
    // **************************************************

    startWhenIdle: assert property (
        @(posedge clock) disable iff (reset) start |-> (state == idle)
    ) else $error("Lookup started while busy.");

    donePulse: assert property (
        @(posedge clock) disable iff (reset) done |=> !done
    ) else $error("Lookup done held longer than one cycle.");

endmodule

//--- affineRequestSequencer.sv
`timescale 1ns/1ps

module affineRequestSequencer (
    input  logic                clock,
    input  logic                reset,
    input  logic                reqValid,
    output logic                reqReady,
    input  objPkg::pixelRequest req,
    input  logic                oamWrValid,
    output logic                lookupStart,
    output objPkg::affineIndex  lookupIndex,
    input  logic                lookupDone,
    input  objPkg::affineSet    lookupParams,
    output logic                jobValid,
    input  logic                jobReady,
    output objPkg::transformJob job
);

    import objPkg::*;

    typedef enum logic [1:0] {
        seqIdle,
        seqStart,
        seqWait,
        seqOffer
    } seqState;

    seqState     state, nextState;
    pixelRequest heldReq;
    affineSet    cacheParams;
    affineIndex  cacheIndex;
    logic        cacheValid;
    logic        cacheHit;
    logic        lookupDirty;   // OAM changed while the lookup was reading.
    logic        reqFire;
    logic        jobFire;
    logic        fill;

    assign reqFire = reqValid && reqReady;
    assign jobFire = jobValid && jobReady;
    assign fill    = (state == seqWait) && lookupDone;

    // A write in the same cycle forces a miss so the lookup sees the new data.
    assign cacheHit = cacheValid && !oamWrValid && (cacheIndex == req.index);

    assign reqReady    = (state == seqIdle);
    assign lookupStart = (state == seqStart);
    assign jobValid    = (state == seqOffer);
    assign lookupIndex = heldReq.index;
    assign job         = '{req: heldReq, params: cacheParams};

    always_comb begin
        nextState = state;
        case (state)
            seqIdle:  if (reqFire) nextState = cacheHit ? seqOffer : seqStart;
            seqStart: nextState = seqWait;
            seqWait:  if (lookupDone) nextState = seqOffer;
            seqOffer: if (jobFire) nextState = seqIdle;
            default:  nextState = seqIdle;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state       <= seqIdle;
            cacheValid  <= 1'b0;
            lookupDirty <= 1'b0;
        end else begin
            state <= nextState;
            if (state == seqStart) lookupDirty <= 1'b0;
            else if (oamWrValid) lookupDirty <= 1'b1;
            if (oamWrValid) cacheValid <= 1'b0;
            else if (fill) cacheValid <= !lookupDirty;
        end
    end

    always_ff @(posedge clock) begin
        if (reqFire) heldReq <= req;
        if (fill) begin
            cacheParams <= lookupParams;
            cacheIndex  <= heldReq.index;
        end
    end

    jobStable: assert property (
        @(posedge clock) disable iff (reset)
        jobValid && !jobReady |=> jobValid && $stable(job)
    ) else $error("Job changed while stalled.");

endmodule

//--- affineTransformUnit.sv
`timescale 1ns/1ps

module affineTransformUnit (
    input  logic                clock,
    input  logic                reset,
    input  logic                jobValid,
    output logic                jobReady,
    input  objPkg::transformJob job,
    output logic                resValid,
    input  logic                resReady,
    output objPkg::texResult    res
);

    import objPkg::*;

    typedef logic signed [$bits(affineParam)+$bits(pixelOffset)-1:0] productWord;
    typedef logic signed [$bits(productWord):0]                       sumWord;

    logic       valid1;
    logic       valid2;
    productWord prodA, prodB, prodC, prodD;
    sumWord     sumX, sumY;
    sumWord     shiftX, shiftY;

    // Everything moves together; a full output stage that is not taken stalls both.
    assign jobReady = !valid2 || resReady;
    assign resValid = valid2;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
        end else if (jobReady) begin
            valid1 <= jobValid;
            valid2 <= valid1;
        end
    end

    // **************************************************
    // Stage 1 registers the signed products
    // **************************************************

    always_ff @(posedge clock) begin
        if (jobReady && jobValid) begin
            prodA <= $signed(job.params.pa) * $signed(job.req.dx);
            prodB <= $signed(job.params.pb) * $signed(job.req.dy);
            prodC <= $signed(job.params.pc) * $signed(job.req.dx);
            prodD <= $signed(job.params.pd) * $signed(job.req.dy);
        end
    end

    // **************************************************
    // Stage 2 turns the sums back into integer texels
    // **************************************************

    always_comb begin
        sumX   = prodA + prodB;
        sumY   = prodC + prodD;
        shiftX = sumX >>> fracBits;   // Drop the fraction, keeping the sign.
        shiftY = sumY >>> fracBits;
    end

    always_ff @(posedge clock) begin
        if (jobReady && valid1) begin
            res.tx <= texCoord'(shiftX);   // truncated to 16 bits
            res.ty <= texCoord'(shiftY);
        end
    end

endmodule

//--- affineObjectEngine.sv
`timescale 1ns/1ps

module affineObjectEngine (
    input  logic                clock,
    input  logic                reset,
    input  objPkg::oamWrite     oamWr,
    input  logic                oamWrValid,
    input  logic                reqValid,
    output logic                reqReady,
    input  objPkg::pixelRequest req,
    output logic                resValid,
    input  logic                resReady,
    output objPkg::texResult    res
);

    import objPkg::*;

    oamAddr      oamRdAddr;
    logic        oamRdEn;
    oamWord      oamRdData;
    logic        lookupStart;
    affineIndex  lookupIndex;
    logic        lookupDone;
    affineSet    lookupParams;
    logic        jobValid;
    logic        jobReady;
    transformJob job;

    oamMemory i_oam (
        .clock, .wr(oamWr), .wrValid(oamWrValid),
        .rdAddr(oamRdAddr), .rdEn(oamRdEn), .rdData(oamRdData)
    );

    attributeLookupUnit i_lookup (
        .clock, .reset, .start(lookupStart), .index(lookupIndex),
        .oamAddress(oamRdAddr), .readOam(oamRdEn), .oamData(oamRdData),
        .params(lookupParams), .done(lookupDone)
    );

    affineRequestSequencer i_sequencer (
        .clock, .reset, .reqValid, .reqReady, .req, .oamWrValid,
        .lookupStart, .lookupIndex, .lookupDone, .lookupParams,
        .jobValid, .jobReady, .job
    );

    affineTransformUnit i_transform (
        .clock, .reset, .jobValid, .jobReady, .job,
        .resValid, .resReady, .res
    );

endmodule

//--- tbAffineObjectEngine.sv
`timescale 1ns/1ps

module tbAffineObjectEngine;

    import objPkg::*;

    localparam int waitLimit = 2000;

    logic         clock;
    logic         reset;
    oamWrite      oamWr;
    logic         oamWrValid;
    logic         reqValid;
    logic         reqReady;
    pixelRequest  req;
    logic         resValid;
    logic         resReady;
    texResult     res;

    oamWord       shadowOam [oamWords];   // What the DUT's OAM should hold.
    texResult     expectedQ [$];
    string        testName;
    logic         stallResults;
    logic [255:0] stallPattern;

    affineObjectEngine i_dut (
        .clock(clock), .reset(reset), .oamWr(oamWr), .oamWrValid(oamWrValid),
        .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .resValid(resValid), .resReady(resReady), .res(res)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // **************************************************
    // Reference model and compare tasks
    // **************************************************

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic checkTexResult(input string name, input texResult expected,
                                  input texResult actual);
        if (actual !== expected) begin
            stopOnError($sformatf("FAIL %s: expected tx=%0d ty=%0d, actual tx=%0d ty=%0d",
                                  name, expected.tx, expected.ty, actual.tx, actual.ty));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stopOnError($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // PA..PD sit in the upper halfword at byte offsets 6, 14, 22 and 30 of a group.
    function automatic affineSet paramsOf(input affineIndex index);
        affineSet p;
        int       addr;
        addr = int'(index) * groupStride + paramOffset;
        p.pa = affineParam'(shadowOam[addr / 4][31:16]);
        p.pb = affineParam'(shadowOam[(addr + paramStep) / 4][31:16]);
        p.pc = affineParam'(shadowOam[(addr + 2 * paramStep) / 4][31:16]);
        p.pd = affineParam'(shadowOam[(addr + 3 * paramStep) / 4][31:16]);
        return p;
    endfunction

    function automatic texResult expectedTex(input affineSet p, input pixelRequest r);
        int       sumX;
        int       sumY;
        texResult t;
        sumX = int'(p.pa) * int'(r.dx) + int'(p.pb) * int'(r.dy);
        sumY = int'(p.pc) * int'(r.dx) + int'(p.pd) * int'(r.dy);
        t.tx = texCoord'(sumX >>> 8);   // Arithmetic shift, then keep 16 bits.
        t.ty = texCoord'(sumY >>> 8);
        return t;
    endfunction

    // **************************************************
    // Stimulus tasks enter and leave just after a falling edge
    // **************************************************

    task automatic writeOam(input oamAddr addr, input oamWord data);
        oamWr.addr = addr;
        oamWr.data = data;
        oamWrValid = 1'b1;
        shadowOam[addr >> 2] = data;
        @(negedge clock);
        oamWrValid = 1'b0;
    endtask

    task automatic setParams(input affineIndex index, input affineSet p);
        affineParam values [4];
        int         addr;
        values = '{p.pa, p.pb, p.pc, p.pd};
        for (int k = 0; k < 4; k++) begin
            addr = int'(index) * groupStride + paramOffset + k * paramStep;
            writeOam(oamAddr'(addr & ~3), {values[k], shadowOam[addr / 4][15:0]});
        end
    endtask

    task automatic sendRequest(input affineIndex index, input pixelOffset dx,
                               input pixelOffset dy);
        pixelRequest r;
        int          count;
        r.index  = index;
        r.dx     = dx;
        r.dy     = dy;
        req      = r;
        reqValid = 1'b1;
        count    = 0;
        while (!reqReady) begin
            @(negedge clock);
            count++;
            if (count > waitLimit) stopOnError("Timed out waiting for reqReady to rise.");
        end
        expectedQ.push_back(expectedTex(paramsOf(index), r));   // Transfer on next edge.
        @(negedge clock);
        reqValid = 1'b0;
    endtask

    task automatic drainResults;
        int count;
        count = 0;
        while (expectedQ.size() != 0) begin
            @(negedge clock);
            count++;
            if (count > waitLimit) stopOnError("Timed out waiting for outstanding results.");
        end
    endtask

    // **************************************************
    // Result side
    // **************************************************

    initial begin : readyDriver
        int cycle;
        cycle    = 0;
        resReady = 1'b1;
        forever begin
            @(negedge clock);
            resReady = !stallResults || stallPattern[cycle % 256];
            cycle++;
        end
    end

    // Sampled after the falling edge, so valid and ready are both settled.
    initial begin
        forever begin
            @(negedge clock);
            #1;
            if (resValid && resReady) begin
                if (expectedQ.size() == 0) stopOnError("A result arrived with no request pending.");
                else checkTexResult(testName, expectedQ.pop_front(), res);
            end
        end
    end

    initial begin
        affineIndex idx;
        int         runLength;
        affineSet   oldSet;
        int         offsets [2];
        void'($urandom(32'hfa94_d18a));
        reset        = 1'b1;
        oamWr        = '0;
        oamWrValid   = 1'b0;
        reqValid     = 1'b0;
        req          = '0;
        stallResults = 1'b0;
        testName     = "reset";
        for (int i = 0; i < 8; i++) stallPattern[i * 32 +: 32] = $urandom;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        checkBit("reset resValid", 1'b0, resValid);
        checkBit("reset reqReady", 1'b1, reqReady);

        testName = "all groups";
        for (int w = 0; w < oamWords; w++) writeOam(oamAddr'(w * 4), $urandom);
        for (int g = 0; g < affineGroups; g++) begin
            sendRequest(affineIndex'(g), pixelOffset'($urandom), pixelOffset'($urandom));
        end
        drainResults();

        testName = "cache hits";
        repeat (15) begin
            idx       = affineIndex'($urandom_range(31, 0));
            runLength = $urandom_range(4, 1);
            repeat (runLength) sendRequest(idx, pixelOffset'($urandom), pixelOffset'($urandom));
        end
        drainResults();

        testName     = "back-pressure";
        stallResults = 1'b1;
        repeat (60) begin
            sendRequest(affineIndex'($urandom_range(3, 0)), pixelOffset'($urandom),
                        pixelOffset'($urandom));
        end
        drainResults();
        stallResults = 1'b0;

        testName = "cache invalidate";
        sendRequest(affineIndex'(7), pixelOffset'(100), pixelOffset'(-37));
        drainResults();
        oldSet = paramsOf(affineIndex'(7));
        setParams(affineIndex'(7), ~oldSet);   // Every parameter changes.
        sendRequest(affineIndex'(7), pixelOffset'(100), pixelOffset'(-37));
        drainResults();

        testName = "extremes";
        offsets  = '{-511, 511};
        setParams(affineIndex'(9), '{pa: 16'h8000, pb: 16'h7fff, pc: 16'h7fff, pd: 16'h8000});
        setParams(affineIndex'(10), '{pa: 16'h7fff, pb: 16'h7fff, pc: 16'h8000, pd: 16'h8000});
        for (int g = 9; g <= 10; g++) begin
            for (int i = 0; i < 2; i++) begin
                for (int j = 0; j < 2; j++) begin
                    sendRequest(affineIndex'(g), pixelOffset'(offsets[i]),
                                pixelOffset'(offsets[j]));
                end
            end
        end
        drainResults();

        repeat (20) @(negedge clock);   // Room for a stray extra result to show up.
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- files.f
objPkg.sv
oamMemory.sv
attributeLookupUnit.sv
affineRequestSequencer.sv
affineTransformUnit.sv
affineObjectEngine.sv
tbAffineObjectEngine.sv

//--- Bender.yml
package:
  name: affine_object_engine

sources:
  - objPkg.sv
  - oamMemory.sv
  - attributeLookupUnit.sv
  - affineRequestSequencer.sv
  - affineTransformUnit.sv
  - affineObjectEngine.sv
  - target: test
    files:
      - tbAffineObjectEngine.sv
